// File: source/pc2drone_defs.svh
/* PC to drone bridge timing constants */
`ifndef PC2DRONE_DEFS_SVH
`define PC2DRONE_DEFS_SVH

// Serial line, clock cycles per bit
`define UART_BIT_CYCLES 24
// Offset from start edge to bit center
`define UART_HALF_CYCLES 12

// Marker byte opening a command frame
`define FRAME_START 8'hA5

// Pulse width for a zero command byte
`define PPM_MIN_PULSES 8261
// Cycles added per command step
`define PPM_GAIN 48
// Trim weight as a left shift, x8
`define PPM_TRIM_SHIFT 3

// Low gap ahead of every channel pulse
`define PPM_SEP_CYCLES 300
// Total frame period in cycles
`define PPM_FRAME_CYCLES 100000

// Room for widths up to about 21.5k cycles
`define PPM_WIDTH_BITS 15

`endif

// File: source/pc2drone_pkg.sv
/* PC to drone shared types */
`include "pc2drone_defs.svh"

package pc2drone_pkg;

    // Channels carried per command frame and per PPM frame
    localparam int NUM_CHANNELS = 4;

    // Serial receiver
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

    // Frame decoder
    typedef enum logic [1:0] {
        HUNT,
        PAYLOAD,
        CHECK
    } dec_state_t;

    // PPM encoder phases
    typedef enum logic [1:0] {
        SEP,
        PULSE,
        SYNC
    } ppm_state_t;

    typedef logic [`PPM_WIDTH_BITS-1:0] pulse_width_t;

endpackage

// File: source/pc2drone_if.sv
/* Command and pulse buses */
`timescale 1ns/1ps

// Decoded frame, fields held until the next good frame
interface cmd_if;
    import pc2drone_pkg::*;

    logic valid;
    logic [7:0] chan [NUM_CHANNELS];
    logic signed [7:0] trim [NUM_CHANNELS];

    modport source (output valid, output chan, output trim);
    modport sink (input valid, input chan, input trim);
endinterface

// Scaled widths toward the PPM encoder
interface pulse_if;
    import pc2drone_pkg::*;

    logic valid;
    pulse_width_t width [NUM_CHANNELS];

    modport source (output valid, output width);
    modport sink (input valid, input width);
endinterface

// File: source/uart_rx.sv
/* 8N1 serial byte receiver */
`timescale 1ns/1ps
`include "pc2drone_defs.svh"

module uart_rx (
    input  logic       clk_system,
    input  logic       rst,
    input  logic       sdin,
    output logic [7:0] data,
    output logic       data_valid
);
    import pc2drone_pkg::*;

    localparam int CNT_BITS = $clog2(`UART_BIT_CYCLES);

    logic [1:0] sync_q;
    logic rx;
    rx_state_t state;
    logic [CNT_BITS-1:0] cyc_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift;
    logic bit_tick;

    // Two flops against metastability, idle line is high
    always_ff @(posedge clk_system) begin
        if (rst) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], sdin};
        end
    end

    assign rx = sync_q[1];
    // One full bit elapsed since the last sample point
    assign bit_tick = (cyc_cnt == CNT_BITS'(`UART_BIT_CYCLES - 1));

    always_ff @(posedge clk_system) begin
        if (rst) begin
            state <= IDLE;
            cyc_cnt <= '0;
            bit_idx <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= 1'b0;
            cyc_cnt <= cyc_cnt + 1'b1;
            case (state)
                IDLE: begin
                    cyc_cnt <= '0;
                    // Falling edge opens a start bit
                    if (!rx) state <= START;
                end
                START: begin
                    // Glitch filter, start bit must still be low mid-bit
                    if (cyc_cnt == CNT_BITS'(`UART_HALF_CYCLES - 1)) begin
                        cyc_cnt <= '0;
                        bit_idx <= '0;
                        state <= rx ? IDLE : DATA;
                    end
                end
                DATA: begin
                    if (bit_tick) begin
                        cyc_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end
                end
                STOP: begin
                    if (bit_tick) begin
                        // Framing error drops the byte silently
                        data_valid <= rx;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk_system) begin
        if (state == DATA && bit_tick) shift <= {rx, shift[7:1]};
        if (state == STOP && bit_tick && rx) data <= shift;
    end

endmodule

// File: source/command_frame_decoder.sv
/* Command frame decoder */
`timescale 1ns/1ps
`include "pc2drone_defs.svh"

module command_frame_decoder (
    input  logic       clk_system,
    input  logic       rst,
    input  logic [7:0] data,
    input  logic       data_valid,
    cmd_if.source      cmd
);
    import pc2drone_pkg::*;

    // Channel bytes then trims
    localparam int PAYLOAD_BYTES = 2 * NUM_CHANNELS;
    localparam int IDX_BITS = $clog2(PAYLOAD_BYTES);

    dec_state_t state;
    logic [IDX_BITS-1:0] idx;
    logic [7:0] csum;
    logic [7:0] stage [PAYLOAD_BYTES];
    logic match;

    // Checksum byte agrees with running XOR
    assign match = data_valid && (state == CHECK) && (data == csum);

    always_ff @(posedge clk_system) begin
        if (rst) begin
            state <= HUNT;
            idx <= '0;
            csum <= '0;
            cmd.valid <= 1'b0;
        end else begin
            cmd.valid <= match;
            case (state)
                HUNT: begin
                    // Anything but the marker is discarded here
                    if (data_valid && data == `FRAME_START) begin
                        idx <= '0;
                        csum <= '0;
                        state <= PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    if (data_valid) begin
                        csum <= csum ^ data;
                        idx <= idx + 1'b1;
                        if (idx == IDX_BITS'(PAYLOAD_BYTES - 1)) state <= CHECK;
                    end
                end
                CHECK: begin
                    // Good or bad, go look for the next marker
                    if (data_valid) state <= HUNT;
                end
                default: state <= HUNT;
            endcase
        end
    end

    // Staging keeps a bad frame away from the outputs
    always_ff @(posedge clk_system) begin
        if (state == PAYLOAD && data_valid) stage[idx] <= data;
        if (match) begin
            for (int k = 0; k < NUM_CHANNELS; k++) begin
                cmd.chan[k] <= stage[k];
                cmd.trim[k] <= $signed(stage[k + NUM_CHANNELS]);
            end
        end
    end

endmodule

// File: source/channel_scaler.sv
/* Command to pulse width scaler */
`timescale 1ns/1ps
`include "pc2drone_defs.svh"

module channel_scaler (
    input  logic                       clk_system,
    input  logic                       rst,
    input  logic [7:0]                 cmd_byte,
    input  logic signed [7:0]          trim,
    input  logic                       load,
    output pc2drone_pkg::pulse_width_t width
);
    import pc2drone_pkg::*;

    int scaled;

    // Offset plus gain, trim sign-extended then weighted
    always_comb begin
        scaled = `PPM_MIN_PULSES + int'(cmd_byte) * `PPM_GAIN
            + (int'(trim) <<< `PPM_TRIM_SHIFT);
    end

    // Result stays in range, worst case near 21.5k cycles
    always_ff @(posedge clk_system) begin
        if (rst) begin
            width <= pulse_width_t'(`PPM_MIN_PULSES);
        end else if (load) begin
            width <= pulse_width_t'(scaled);
        end
    end

endmodule

// File: source/ppm_encoder.sv
/* Four-channel PPM encoder */
`timescale 1ns/1ps
`include "pc2drone_defs.svh"

module ppm_encoder (
    input  logic  clk_system,
    input  logic  rst,
    pulse_if.sink pulses,
    output logic  ppm_output
);
    import pc2drone_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_CHANNELS);
    // One extra count marks the closing separator
    localparam int CH_BITS = $clog2(NUM_CHANNELS + 1);
    localparam int FRAME_BITS = $clog2(`PPM_FRAME_CYCLES);

    pulse_width_t pending [NUM_CHANNELS];
    pulse_width_t shadow [NUM_CHANNELS];
    ppm_state_t state;
    logic [CH_BITS-1:0] ch;
    pulse_width_t state_cnt;
    logic [FRAME_BITS-1:0] frame_cnt;
    pulse_width_t cur_width;
    logic frame_start;
    logic sep_done;
    logic pulse_done;

    assign cur_width = shadow[ch[IDX_BITS-1:0]];
    // Fixed period, independent of the widths
    assign frame_start = (frame_cnt == FRAME_BITS'(`PPM_FRAME_CYCLES - 1));
    assign sep_done = (state_cnt == pulse_width_t'(`PPM_SEP_CYCLES - 1));
    assign pulse_done = (state_cnt == cur_width - 1'b1);

    // Latest widths wait in pending, shadow only changes at frame start
    always_ff @(posedge clk_system) begin
        if (rst) begin
            for (int k = 0; k < NUM_CHANNELS; k++) begin
                pending[k] <= pulse_width_t'(`PPM_MIN_PULSES);
                shadow[k] <= pulse_width_t'(`PPM_MIN_PULSES);
            end
        end else begin
            for (int k = 0; k < NUM_CHANNELS; k++) begin
                if (pulses.valid) pending[k] <= pulses.width[k];
                if (frame_start) shadow[k] <= pending[k];
            end
        end
    end

    always_ff @(posedge clk_system) begin
        if (rst) begin
            // Idle high, first frame opens right after reset
            state <= SYNC;
            ch <= '0;
            state_cnt <= '0;
            frame_cnt <= FRAME_BITS'(`PPM_FRAME_CYCLES - 1);
            ppm_output <= 1'b1;
        end else if (frame_start) begin
            state <= SEP;
            ch <= '0;
            state_cnt <= '0;
            frame_cnt <= '0;
            ppm_output <= 1'b0;
        end else begin
            frame_cnt <= frame_cnt + 1'b1;
            state_cnt <= state_cnt + 1'b1;
            case (state)
                SEP: begin
                    if (sep_done) begin
                        state_cnt <= '0;
                        ppm_output <= 1'b1;
                        state <= (ch == CH_BITS'(NUM_CHANNELS)) ? SYNC : PULSE;
                    end
                end
                PULSE: begin
                    if (pulse_done) begin
                        state_cnt <= '0;
                        ppm_output <= 1'b0;
                        ch <= ch + 1'b1;
                        state <= SEP;
                    end
                end
                // High until the frame counter wraps
                SYNC: state_cnt <= '0;
                default: state <= SYNC;
            endcase
        end
    end

endmodule

// File: source/pc2drone.sv
/* PC to drone PPM bridge */
`timescale 1ns/1ps

module pc2drone (
    input  logic clk_system,
    input  logic rst,
    input  logic uart_input_pc,
    output logic ppm_output
);
    import pc2drone_pkg::*;

    logic [7:0] pc_data;
    logic pc_data_valid;

    cmd_if cmd_bus ();
    pulse_if pulse_bus ();

    // Bytes from the PC serial line
    uart_rx uart_pc (
        .clk_system (clk_system),
        .rst        (rst),
        .sdin       (uart_input_pc),
        .data       (pc_data),
        .data_valid (pc_data_valid)
    );

    command_frame_decoder commands_decoder (
        .clk_system (clk_system),
        .rst        (rst),
        .data       (pc_data),
        .data_valid (pc_data_valid),
        .cmd        (cmd_bus)
    );

    // One scaler per channel, all loaded by the same strobe
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_scaler
        channel_scaler scaler (
            .clk_system (clk_system),
            .rst        (rst),
            .cmd_byte   (cmd_bus.chan[i]),
            .trim       (cmd_bus.trim[i]),
            .load       (cmd_bus.valid),
            .width      (pulse_bus.width[i])
        );
        // Valid follows the scaler register by one cycle
        if (i == 0) begin : g_valid
            always_ff @(posedge clk_system) begin
                if (rst) begin
                    pulse_bus.valid <= 1'b0;
                end else begin
                    pulse_bus.valid <= cmd_bus.valid;
                end
            end
        end
    end

    ppm_encoder ppm_enc (
        .clk_system (clk_system),
        .rst        (rst),
        .pulses     (pulse_bus),
        .ppm_output (ppm_output)
    );

endmodule

// File: bench/pc2drone_asserts.sv
/* PPM bridge assertions */
`timescale 1ns/1ps
`include "pc2drone_defs.svh"

module pc2drone_asserts (
    input logic clk_system,
    input logic rst,
    input logic data_valid,
    input logic cmd_valid,
    input logic ppm_output
);
    int low_cnt;

    // Consecutive low cycles on the PPM line
    always_ff @(posedge clk_system) begin
        if (rst || ppm_output) begin
            low_cnt <= 0;
        end else begin
            low_cnt <= low_cnt + 1;
        end
    end

    // Strobes last a single cycle
    a_byte_strobe: assert property (@(posedge clk_system) disable iff (rst)
        data_valid |=> !data_valid)
        else $error("data_valid high two cycles in a row");

    a_cmd_strobe: assert property (@(posedge clk_system) disable iff (rst)
        cmd_valid |=> !cmd_valid)
        else $error("cmd valid high two cycles in a row");

    // Output register idles high under reset
    a_reset_high: assert property (@(posedge clk_system) rst |=> ppm_output)
        else $error("ppm_output low during reset");

    // Only separators pull the line low
    a_sep_length: assert property (@(posedge clk_system) disable iff (rst)
        !ppm_output |-> low_cnt < `PPM_SEP_CYCLES)
        else $error("ppm_output low longer than a separator");

endmodule

bind pc2drone pc2drone_asserts checks (
    .clk_system (clk_system),
    .rst        (rst),
    .data_valid (pc_data_valid),
    .cmd_valid  (cmd_bus.valid),
    .ppm_output (ppm_output)
);

// File: bench/pc2drone_tb.sv
/* PC to drone bridge testbench */
`timescale 1ns/1ps
`include "pc2drone_defs.svh"

module pc2drone_tb;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 5;
    localparam int NUM_TESTS = 6;
    // Three PPM frames per test at most
    localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * 3 * `PPM_FRAME_CYCLES * CLK_PERIOD;

    logic clk_system;
    logic rst;
    logic uart_input_pc;
    logic ppm_output;

    logic [31:0] lfsr = 32'h95c8_9280;
    logic [7:0] payload [8];
    int exp_w [4] = '{`PPM_MIN_PULSES, `PPM_MIN_PULSES, `PPM_MIN_PULSES, `PPM_MIN_PULSES};
    int errors = 0;
    int pass_count = 0;
    int fail_count = 0;

    // Monitor state sampled on the falling clock edge
    int cyc = 0;
    int frame_starts = 0;
    int fall_idx = 0;
    int rise_cyc = 0;
    int start_cyc = 0;
    int hi_w [4];
    int meas_w [4];
    int meas_period = 0;
    logic ppm_prev = 1'b1;

    pc2drone UUT (
        .clk_system    (clk_system),
        .rst           (rst),
        .uart_input_pc (uart_input_pc),
        .ppm_output    (ppm_output)
    );

    initial begin
        clk_system = 1'b0;
        forever #(CLK_PERIOD / 2) clk_system = ~clk_system;
    end

    // Five falling edges per frame with the first one opening channel 1
    always @(negedge clk_system) begin
        cyc = cyc + 1;
        if (!rst) begin
            if (ppm_prev && !ppm_output) begin
                if (fall_idx == 0) begin
                    if (frame_starts > 0) begin
                        for (int k = 0; k < 4; k++) meas_w[k] = hi_w[k];
                        meas_period = cyc - start_cyc;
                    end
                    start_cyc = cyc;
                    frame_starts = frame_starts + 1;
                end else begin
                    hi_w[fall_idx - 1] = cyc - rise_cyc;
                end
                fall_idx = (fall_idx == 4) ? 0 : fall_idx + 1;
            end
            if (!ppm_prev && ppm_output) rise_cyc = cyc;
            ppm_prev = ppm_output;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Offset plus gain per step plus signed trim times 8
    function automatic void apply_model();
        for (int k = 0; k < 4; k++) begin
            exp_w[k] = `PPM_MIN_PULSES + int'(payload[k]) * `PPM_GAIN
                + int'($signed(payload[k + 4])) * (1 << `PPM_TRIM_SHIFT);
        end
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == 0) begin
            $display("test %s: ok", name);
            pass_count = pass_count + 1;
        end else begin
            $display("test %s: %0d mismatches", name, errors);
            fail_count = fail_count + 1;
        end
        errors = 0;
    endtask

    // Entered and left a small delay after a rising edge
    task automatic send_bit(input logic v);
        uart_input_pc = v;
        repeat (`UART_BIT_CYCLES) @(posedge clk_system);
        #DRIVE_DELAY;
    endtask

    task automatic send_byte(input logic [7:0] b, input bit stop_ok);
        send_bit(1'b0);
        for (int i = 0; i < 8; i++) send_bit(b[i]);
        send_bit(stop_ok);
        // Longer idle after a bad stop bit since the receiver retriggers on the low line
        repeat (stop_ok ? 1 : 3) send_bit(1'b1);
    endtask

    task automatic fill_payload(input logic [7:0] mask);
        for (int k = 0; k < 8; k++) payload[k] = 8'(rand_bits(8)) & mask;
    endtask

    // bad_stop picks the byte with a 0 stop bit or -1 for none
    task automatic send_frame(input logic [7:0] csum_err, input int bad_stop);
        logic [7:0] csum;
        csum = '0;
        for (int k = 0; k < 8; k++) csum = csum ^ payload[k];
        send_byte(`FRAME_START, bad_stop != 0);
        for (int k = 0; k < 8; k++) send_byte(payload[k], bad_stop != k + 1);
        send_byte(csum ^ csum_err, bad_stop != 9);
    endtask

    // Compare the frame that closes when frame start number end_start is seen
    task automatic compare_frame_at(input string name, input int end_start, input bit with_period);
        while (frame_starts < end_start) @(posedge clk_system);
        #DRIVE_DELAY;
        for (int k = 0; k < 4; k++) begin
            check_value($sformatf("%s ch%0d", name, k + 1), exp_w[k], meas_w[k]);
        end
        if (with_period) check_value({name, " period"}, `PPM_FRAME_CYCLES, meas_period);
    endtask

    // Measure the first whole frame that starts from now on
    task automatic verify_next_frame(input string name, input bit with_period);
        compare_frame_at(name, frame_starts + 2, with_period);
    endtask

    initial begin
        int seen;
        rst = 1'b1;
        uart_input_pc = 1'b1;
        repeat (4) @(posedge clk_system);
        #DRIVE_DELAY;
        rst = 1'b0;

        verify_next_frame("reset_defaults", 1'b1);
        finish_test("reset_defaults");

        repeat (2) begin
            fill_payload(8'hFF);
            send_frame(8'h00, -1);
            apply_model();
            verify_next_frame("random_frames", 1'b0);
        end
        finish_test("random_frames");

        // Model untouched so the previous widths are expected
        fill_payload(8'hFF);
        send_frame(8'(rand_bits(8)) | 8'h01, -1);
        verify_next_frame("bad_checksum", 1'b0);
        finish_test("bad_checksum");

        // Marker lost and the masked payload never looks like a marker
        fill_payload(8'h7F);
        send_frame(8'h00, 0);
        verify_next_frame("stop_bit_error dropped", 1'b0);
        fill_payload(8'hFF);
        send_frame(8'h00, -1);
        apply_model();
        verify_next_frame("stop_bit_error", 1'b0);
        finish_test("stop_bit_error");

        repeat (5) send_byte(8'(rand_bits(8)) & 8'h7F, 1'b1);
        fill_payload(8'hFF);
        send_frame(8'h00, -1);
        apply_model();
        verify_next_frame("leading_noise", 1'b0);
        finish_test("leading_noise");

        // Both frames land between two frame starts
        seen = frame_starts;
        while (frame_starts == seen) @(posedge clk_system);
        #DRIVE_DELAY;
        repeat (2) begin
            fill_payload(8'hFF);
            send_frame(8'h00, -1);
        end
        // Frame in flight keeps the widths it opened with
        compare_frame_at("back_to_back held", seen + 2, 1'b0);
        apply_model();
        compare_frame_at("back_to_back", seen + 3, 1'b0);
        finish_test("back_to_back");

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests completed");
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+source
source/pc2drone_pkg.sv
source/pc2drone_if.sv
source/uart_rx.sv
source/command_frame_decoder.sv
source/channel_scaler.sv
source/ppm_encoder.sv
source/pc2drone.sv
bench/pc2drone_asserts.sv
bench/pc2drone_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module pc2drone_tb -Mdir obj_dir

run: compile
	./obj_dir/Vpc2drone_tb | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
